//--- common/tlbPkg.sv
`default_nettype none

package tlbPkg;

	// table size
	localparam int TLB_ENTRIES = 32;
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);

	// address widths
	localparam int VADDR_W = 32;
	localparam int PADDR_W = 32;
	localparam int PAGE_OFS_W = 12;

	// even/odd page select sits just above the 4 KiB offset
	localparam int ODD_PAGE_BIT = PAGE_OFS_W;

	// field widths
	localparam int VPN2_W = VADDR_W - PAGE_OFS_W - 1;
	localparam int PFN_W = PADDR_W - PAGE_OFS_W;
	localparam int ASID_W = 8;
	localparam int CATTR_W = 3;

	// one page group is PFN, C, D, V from msb down
	localparam int PAGE_V_BIT = 0;
	localparam int PAGE_D_BIT = 1;
	localparam int PAGE_C_LSB = 2;
	localparam int PAGE_PFN_LSB = PAGE_C_LSB + CATTR_W;
	localparam int PAGE_W = PAGE_PFN_LSB + PFN_W;

	// entry word, from msb down
	//   VPN2 | ASID | G | odd page | even page
	// even page group starts at bit 0
	localparam int PAGE1_LSB = PAGE_W;
	localparam int ENTRY_G_BIT = 2 * PAGE_W;
	localparam int ENTRY_ASID_LSB = ENTRY_G_BIT + 1;
	localparam int ENTRY_VPN2_LSB = ENTRY_ASID_LSB + ASID_W;
	localparam int TLB_ENTRY_W = ENTRY_VPN2_LSB + VPN2_W;

	// vector types
	typedef logic [TLB_IDX_W-1:0] tlbIdxT;
	typedef logic [VADDR_W-1:0] vaddrT;
	typedef logic [PADDR_W-1:0] paddrT;
	typedef logic [VPN2_W-1:0] vpn2T;
	typedef logic [PFN_W-1:0] pfnT;
	typedef logic [ASID_W-1:0] asidT;
	typedef logic [CATTR_W-1:0] cattrT;
	typedef logic [TLB_ENTRY_W-1:0] tlbEntryT;

	// cache attribute code that bypasses the caches
	localparam cattrT CACHE_UNCACHED = cattrT'(2);

endpackage

`default_nettype wire

//--- common/tlbXlateIf.sv
`default_nettype none

interface tlbXlateIf
	import tlbPkg::*;
();

	// request
	vaddrT vaddr;

	// result
	paddrT paddr;
	logic  miss;
	logic  dirty;
	logic  valid;
	logic  bypass;

	modport lookup (
		input  vaddr,
		output paddr,
		output miss,
		output dirty,
		output valid,
		output bypass
	);

	modport requester (
		output vaddr,
		input  paddr,
		input  miss,
		input  dirty,
		input  valid,
		input  bypass
	);

endinterface

`default_nettype wire

//--- design/tlbTop.sv
`default_nettype none

module tlbTop
	import tlbPkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	// tlbwi/tlbwr write and tlbr read
	input  logic     wtlb_i,
	input  tlbIdxT   tlbIdx_i,
	input  tlbEntryT tlbWdata_i,
	output tlbEntryT tlbRdata_o,

	// current address space
	input  asidT     asid_i,

	// instruction fetch translation
	input  vaddrT    instVaddr_i,
	output paddrT    instPaddr_o,
	output logic     instMiss_o,
	output logic     instDirty_o,
	output logic     instValid_o,
	output logic     instBypass_o,

	// data access translation
	input  vaddrT    dataVaddr_i,
	output paddrT    dataPaddr_o,
	output logic     dataMiss_o,
	output logic     dataDirty_o,
	output logic     dataValid_o,
	output logic     dataBypass_o,

	// tlbp
	input  vpn2T     probeVpn2_i,
	output logic     probeMiss_o,
	output tlbIdxT   probeIdx_o
);

	tlbEntryT entries [TLB_ENTRIES];

	tlbXlateIf instXlate ();
	tlbXlateIf dataXlate ();

	tlbEntryArray u_entries (
		.clk       (clk),
		.rst_n     (rst_n),
		.we_i      (wtlb_i),
		.idx_i     (tlbIdx_i),
		.wdata_i   (tlbWdata_i),
		.rdata_o   (tlbRdata_o),
		.entries_o (entries)
	);

	// probe shares the match logic of the lookups
	tlbMatchEncoder u_probe (
		.entries_i (entries),
		.vpn2_i    (probeVpn2_i),
		.asid_i    (asid_i),
		.miss_o    (probeMiss_o),
		.idx_o     (probeIdx_o)
	);

	tlbLookup u_instLookup (
		.entries_i (entries),
		.asid_i    (asid_i),
		.xlate     (instXlate)
	);

	tlbLookup u_dataLookup (
		.entries_i (entries),
		.asid_i    (asid_i),
		.xlate     (dataXlate)
	);

	// instruction side requests
	assign instXlate.vaddr = instVaddr_i;
	assign instPaddr_o = instXlate.paddr;
	assign instMiss_o = instXlate.miss;
	assign instDirty_o = instXlate.dirty;
	assign instValid_o = instXlate.valid;
	assign instBypass_o = instXlate.bypass;

	// data side requests
	assign dataXlate.vaddr = dataVaddr_i;
	assign dataPaddr_o = dataXlate.paddr;
	assign dataMiss_o = dataXlate.miss;
	assign dataDirty_o = dataXlate.dirty;
	assign dataValid_o = dataXlate.valid;
	assign dataBypass_o = dataXlate.bypass;

endmodule

`default_nettype wire

//--- dv/tlbTb.sv
`default_nettype none

module tlbTb
	import tlbPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 4;
	localparam int RAND_ROUNDS = 40;

	// one pattern line holds an opcode and up to twelve hex fields
	typedef struct packed {
		logic [7:0]        op;
		logic [11:0][31:0] f;
	} patT;

	logic     clk;
	logic     rst_n;
	logic     wtlb_i;
	tlbIdxT   tlbIdx_i;
	tlbEntryT tlbWdata_i;
	tlbEntryT tlbRdata_o;
	asidT     asid_i;
	vaddrT    instVaddr_i;
	vaddrT    dataVaddr_i;
	vpn2T     probeVpn2_i;
	paddrT    instPaddr_o;
	paddrT    dataPaddr_o;
	logic     instMiss_o;
	logic     instDirty_o;
	logic     instValid_o;
	logic     instBypass_o;
	logic     dataMiss_o;
	logic     dataDirty_o;
	logic     dataValid_o;
	logic     dataBypass_o;
	logic     probeMiss_o;
	tlbIdxT   probeIdx_o;

	tlbEntryT    shadow [TLB_ENTRIES];
	patT         patterns [$];
	logic [31:0] lcgState;
	int          checkCount;
	int          errorCount;
	int          testChecks;
	int          testErrors;
	int          limitCycles;

	tlbTop u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.wtlb_i       (wtlb_i),
		.tlbIdx_i     (tlbIdx_i),
		.tlbWdata_i   (tlbWdata_i),
		.tlbRdata_o   (tlbRdata_o),
		.asid_i       (asid_i),
		.instVaddr_i  (instVaddr_i),
		.instPaddr_o  (instPaddr_o),
		.instMiss_o   (instMiss_o),
		.instDirty_o  (instDirty_o),
		.instValid_o  (instValid_o),
		.instBypass_o (instBypass_o),
		.dataVaddr_i  (dataVaddr_i),
		.dataPaddr_o  (dataPaddr_o),
		.dataMiss_o   (dataMiss_o),
		.dataDirty_o  (dataDirty_o),
		.dataValid_o  (dataValid_o),
		.dataBypass_o (dataBypass_o),
		.probeVpn2_i  (probeVpn2_i),
		.probeMiss_o  (probeMiss_o),
		.probeIdx_o   (probeIdx_o)
	);

	initial clk = 1'b0;

	always #CLK_HALF clk = ~clk;

	// LCG output with its halves swapped so the low bits are the better ones
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {lcgState[15:0], lcgState[31:16]};
	endfunction

	// f[1] to f[11] are vpn2 asid g pfn1 c1 d1 v1 pfn0 c0 d0 v0
	function automatic tlbEntryT packEntry(input logic [11:0][31:0] f);
		tlbEntryT e;

		e = '0;
		e[ENTRY_VPN2_LSB +: VPN2_W] = f[1][VPN2_W-1:0];
		e[ENTRY_ASID_LSB +: ASID_W] = f[2][ASID_W-1:0];
		e[ENTRY_G_BIT] = f[3][0];
		e[PAGE1_LSB + PAGE_PFN_LSB +: PFN_W] = f[4][PFN_W-1:0];
		e[PAGE1_LSB + PAGE_C_LSB +: CATTR_W] = f[5][CATTR_W-1:0];
		e[PAGE1_LSB + PAGE_D_BIT] = f[6][0];
		e[PAGE1_LSB + PAGE_V_BIT] = f[7][0];
		e[PAGE_PFN_LSB +: PFN_W] = f[8][PFN_W-1:0];
		e[PAGE_C_LSB +: CATTR_W] = f[9][CATTR_W-1:0];
		e[PAGE_D_BIT] = f[10][0];
		e[PAGE_V_BIT] = f[11][0];
		return e;
	endfunction

	// first matching shadow entry counting up from 0
	function automatic tlbIdxT findEntry(input vpn2T vpn2, input asidT asid, output logic miss);
		int i;
		tlbEntryT e;

		miss = 1'b1;
		i = 0;
		while (miss && i < TLB_ENTRIES)
		begin
			e = shadow[i];
			if (e[ENTRY_VPN2_LSB +: VPN2_W] == vpn2 &&
				(e[ENTRY_G_BIT] || e[ENTRY_ASID_LSB +: ASID_W] == asid))
				miss = 1'b0;
			else
				i++;
		end
		return miss ? tlbIdxT'(0) : tlbIdxT'(i);
	endfunction

	// flags are miss dirty valid bypass
	task automatic expectXlate(input asidT asid, input vaddrT va, output paddrT pa,
		output logic [3:0] flags);
		logic miss;
		tlbIdxT idx;
		tlbEntryT e;
		logic [PAGE_W-1:0] pg;

		idx = findEntry(va[VADDR_W-1 -: VPN2_W], asid, miss);
		e = shadow[idx];
		pg = va[ODD_PAGE_BIT] ? e[PAGE1_LSB +: PAGE_W] : e[PAGE_W-1:0];
		pa = {pg[PAGE_PFN_LSB +: PFN_W], va[PAGE_OFS_W-1:0]};
		flags = {miss, pg[PAGE_D_BIT], pg[PAGE_V_BIT],
			(pg[PAGE_C_LSB +: CATTR_W] == CACHE_UNCACHED)};
	endtask

	task automatic checkEntry(input string what, input tlbEntryT got, input tlbEntryT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkXlate(input string what, input paddrT gotPa, input paddrT expPa,
		input logic [3:0] gotFlags, input logic [3:0] expFlags);
		checkCount++;
		if (gotPa !== expPa || gotFlags !== expFlags)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s got paddr %h flags %b expected paddr %h flags %b",
				$time, what, gotPa, gotFlags, expPa, expFlags);
		end
	endtask

	task automatic checkProbe(input string what, input logic gotMiss, input logic expMiss,
		input tlbIdxT gotIdx, input tlbIdxT expIdx);
		checkCount++;
		if (gotMiss !== expMiss || gotIdx !== expIdx)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s got miss %b idx %0d expected miss %b idx %0d",
				$time, what, gotMiss, gotIdx, expMiss, expIdx);
		end
	endtask

	task automatic writeEntry(input tlbIdxT idx, input tlbEntryT e);
		@(posedge clk);
		wtlb_i <= 1'b1;
		tlbIdx_i <= idx;
		tlbWdata_i <= e;
		@(posedge clk);
		wtlb_i <= 1'b0;
		shadow[idx] = e;
	endtask

	task automatic sampleXlate(input logic port, output paddrT pa, output logic [3:0] flags);
		if (port)
		begin
			pa = dataPaddr_o;
			flags = {dataMiss_o, dataDirty_o, dataValid_o, dataBypass_o};
		end
		else
		begin
			pa = instPaddr_o;
			flags = {instMiss_o, instDirty_o, instValid_o, instBypass_o};
		end
	endtask

	task automatic loadPatterns(output bit ok);
		int fd;
		int c;
		int nFields;
		logic [7:0] ch;
		logic [31:0] word;
		patT p;

		ok = 1'b1;
		fd = $fopen("dv/tlb_patterns.dat", "r");
		if (fd == 0)
		begin
			$display("could not open the pattern file dv/tlb_patterns.dat");
			ok = 1'b0;
		end
		else
		begin
			c = $fgetc(fd);
			while (c >= 0 && ok)
			begin
				ch = c[7:0];
				nFields = 0;
				if (ch == "#")
				begin
					while (c >= 0 && c != 10)
						c = $fgetc(fd);
				end
				else if (ch == "W" || ch == "R")
					nFields = 12;
				else if (ch == "T")
					nFields = 8;
				else if (ch == "P")
					nFields = 4;
				else if (!(c inside {9, 10, 13, 32}))
				begin
					$display("unexpected character in the pattern file");
					ok = 1'b0;
				end
				if (nFields > 0)
				begin
					p = '0;
					p.op = ch;
					for (int k = 0; k < nFields; k++)
					begin
						if ($fscanf(fd, "%h", word) != 1)
							ok = 1'b0;
						p.f[k] = word;
					end
					if (ok)
						patterns.push_back(p);
					else
						$display("a pattern line has too few fields");
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	task automatic runPattern(input patT p);
		paddrT pa;
		logic [3:0] flags;
		string what;

		case (p.op)
			"W": writeEntry(tlbIdxT'(p.f[0]), packEntry(p.f));
			"R":
			begin
				@(posedge clk);
				tlbIdx_i <= tlbIdxT'(p.f[0]);
				@(negedge clk);
				checkEntry("tlbr", tlbRdata_o, packEntry(p.f));
			end
			"T":
			begin
				@(posedge clk);
				asid_i <= asidT'(p.f[1]);
				if (p.f[0][0])
					dataVaddr_i <= p.f[2];
				else
					instVaddr_i <= p.f[2];
				@(negedge clk);
				what = p.f[0][0] ? "data xlate" : "inst xlate";
				sampleXlate(p.f[0][0], pa, flags);
				checkXlate(what, pa, p.f[3], flags,
					{p.f[4][0], p.f[5][0], p.f[6][0], p.f[7][0]});
			end
			default:
			begin
				@(posedge clk);
				asid_i <= asidT'(p.f[0]);
				probeVpn2_i <= vpn2T'(p.f[1]);
				@(negedge clk);
				checkProbe("probe", probeMiss_o, p.f[2][0], probeIdx_o, tlbIdxT'(p.f[3]));
			end
		endcase
	endtask

	task automatic randomRound();
		logic [11:0][31:0] f;
		logic [31:0] r;
		logic [31:0] q;
		asidT asid;
		vaddrT instVa;
		vaddrT dataVa;
		vpn2T pv;
		tlbIdxT readIdx;
		paddrT pa;
		paddrT expPa;
		logic [3:0] flags;
		logic [3:0] expFlags;
		logic expMiss;
		tlbIdxT expIdx;

		for (int k = 0; k < 12; k++)
		begin
			f[k] = nextRand();
		end
		// small VPN2 and ASID pools so entries collide
		f[1] = {29'd0, f[1][2:0]};
		f[2] = {30'd0, f[2][1:0]};
		f[3] = {31'd0, (f[3][1:0] == 2'b00)};
		writeEntry(tlbIdxT'(f[0]), packEntry(f));

		r = nextRand();
		q = nextRand();
		asid = asidT'(r[1:0]);
		instVa = {vpn2T'(r[4:2]), r[5], r[17:6]};
		dataVa = (q[31:30] == 2'b00) ? instVa : {vpn2T'(q[2:0]), q[3], q[15:4]};
		pv = vpn2T'(q[18:16]);
		readIdx = tlbIdxT'(q[23:19]);
		@(posedge clk);
		asid_i <= asid;
		instVaddr_i <= instVa;
		dataVaddr_i <= dataVa;
		probeVpn2_i <= pv;
		tlbIdx_i <= readIdx;
		@(negedge clk);
		expectXlate(asid, instVa, expPa, expFlags);
		sampleXlate(1'b0, pa, flags);
		checkXlate("random inst xlate", pa, expPa, flags, expFlags);
		expectXlate(asid, dataVa, expPa, expFlags);
		sampleXlate(1'b1, pa, flags);
		checkXlate("random data xlate", pa, expPa, flags, expFlags);
		expIdx = findEntry(pv, asid, expMiss);
		checkProbe("random probe", probeMiss_o, expMiss, probeIdx_o, expIdx);
		checkEntry("random tlbr", tlbRdata_o, shadow[readIdx]);
	endtask

	task automatic finishTest(input string name);
		$display("test %s finished with %0d checks and %0d errors", name,
			checkCount - testChecks, errorCount - testErrors);
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	// watchdog
	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("timeout after %0d cycles, the tests did not complete", limitCycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		bit loadOk;

		rst_n = 1'b0;
		wtlb_i = 1'b0;
		tlbIdx_i = '0;
		tlbWdata_i = '0;
		asid_i = '0;
		instVaddr_i = '0;
		dataVaddr_i = '0;
		probeVpn2_i = '0;
		lcgState = 32'd80823;
		checkCount = 0;
		errorCount = 0;
		testChecks = 0;
		testErrors = 0;
		limitCycles = 0;
		for (int i = 0; i < TLB_ENTRIES; i++)
		begin
			shadow[i] = '0;
		end

		loadPatterns(loadOk);
		if (!loadOk)
		begin
			$display("STATUS: FAIL");
			$finish;
		end
		else
		begin
			// reset readback counts as 32 more patterns
			limitCycles = (patterns.size() + TLB_ENTRIES + RAND_ROUNDS) * 4 + 100;

			repeat (RESET_CYCLES) @(posedge clk);
			rst_n <= 1'b1;
			for (int i = 0; i < TLB_ENTRIES; i++)
			begin
				@(posedge clk);
				tlbIdx_i <= tlbIdxT'(i);
				@(negedge clk);
				checkEntry("tlbr after reset", tlbRdata_o, '0);
			end
			finishTest("reset_readback");

			foreach (patterns[i])
			begin
				runPattern(patterns[i]);
			end
			finishTest("directed_patterns");

			repeat (RAND_ROUNDS) randomRound();
			finishTest("random_lookups");

			$display("total checks %0d, errors %0d", checkCount, errorCount);
			if (errorCount == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- dv/tlbTb_asserts.sv
`default_nettype none

module tlbTbAsserts
	import tlbPkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     wtlb_i,
	input tlbIdxT   tlbIdx_i,
	input tlbEntryT tlbWdata_i,
	input vaddrT    instVaddr_i,
	input vaddrT    dataVaddr_i,
	input paddrT    instPaddr_o,
	input logic     instMiss_o,
	input logic     instDirty_o,
	input logic     instValid_o,
	input logic     instBypass_o,
	input paddrT    dataPaddr_o,
	input logic     dataMiss_o,
	input logic     dataDirty_o,
	input logic     dataValid_o,
	input logic     dataBypass_o,
	input logic     probeMiss_o,
	input tlbIdxT   probeIdx_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// a missing probe reports index 0
	probeIdxOnMiss: assert property (@(posedge clk) disable iff (!rst_n)
		probeMiss_o |-> (probeIdx_o == '0))
	else $error("probe missed but reported a nonzero index");

	// both ports share one table, so equal requests give equal results
	portsAgree: assert property (@(posedge clk) disable iff (!rst_n)
		(instVaddr_i == dataVaddr_i) |->
		({instPaddr_o, instMiss_o, instDirty_o, instValid_o, instBypass_o} ==
		{dataPaddr_o, dataMiss_o, dataDirty_o, dataValid_o, dataBypass_o}))
	else $error("instruction and data results differ for the same address");

	writeKnown: assert property (@(posedge clk) disable iff (!rst_n)
		wtlb_i |-> !$isunknown({tlbIdx_i, tlbWdata_i}))
	else $error("write strobe high with unknown index or data");

endmodule

bind tlbTop tlbTbAsserts u_asserts (.*);

`default_nettype wire

//--- dv/tlb_patterns.dat
# W or R lines give idx vpn2 asid g pfn1 c1 d1 v1 pfn0 c0 d0 v0 in hex
# T lines give port(0 inst 1 data) asid vaddr paddr miss dirty valid bypass
# P lines give asid vpn2 miss idx
T 0 00 00000abc 00000abc 0 0 0 0
W 03 12345 1a 0 abcde 2 1 1 54321 3 0 1
R 03 12345 1a 0 abcde 2 1 1 54321 3 0 1
T 0 1a 2468a123 54321123 0 0 1 0
T 1 1a 2468b456 abcde456 0 1 1 1
T 1 1a 2468a123 54321123 0 0 1 0
T 0 1a 2468b456 abcde456 0 1 1 1
W 03 12345 1a 0 11111 0 0 1 22222 2 1 0
R 03 12345 1a 0 11111 0 0 1 22222 2 1 0
T 1 1a 2468a7ff 222227ff 0 1 0 1
T 0 1b 2468a000 00000000 1 0 0 0
W 05 0abcd 00 1 33333 7 1 1 44444 1 1 1
T 1 77 1579a010 44444010 0 1 1 0
T 0 42 1579b010 33333010 0 1 1 0
W 07 00fff 05 0 aaaaa 0 0 1 bbbbb 2 1 1
W 0a 00fff 05 0 ccccc 3 1 0 ddddd 0 0 1
T 0 05 01ffe000 bbbbb000 0 1 1 1
P 05 00fff 0 07
W 07 00ffe 05 0 aaaaa 0 0 1 bbbbb 2 1 1
P 05 00fff 0 0a
T 1 05 01ffe000 ddddd000 0 0 1 0
P 05 7ffff 1 00

//--- run_sim.sh
#!/usr/bin/env bash
# builds the TLB testbench with Verilator and runs it from the project root

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tlbTb

verilator --binary --timing --assert \
	-Mdir "$BUILD_DIR" \
	--top-module "$TOP" \
	-f tlbUnit.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
	echo "simulation passed, log in $LOG"
	exit 0
else
	echo "simulation failed, log in $LOG"
	exit 1
fi

//--- tlb/tlbEntryArray.sv
`default_nettype none

module tlbEntryArray
	import tlbPkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	// write strobe, one cycle per write
	input  logic     we_i,
	input  tlbIdxT   idx_i,
	input  tlbEntryT wdata_i,

	// indexed read for tlbr
	output tlbEntryT rdata_o,

	// full table for the match logic
	output tlbEntryT entries_o [TLB_ENTRIES]
);

	tlbEntryT entryMem [TLB_ENTRIES];

	// all entries come out of reset as VPN2 0, ASID 0, not global
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < TLB_ENTRIES; i++)
			begin
				entryMem[i] <= '0;
			end
		end
		else if (we_i)
		begin
			entryMem[idx_i] <= wdata_i;
		end
	end

	// tlbr sees the same index as the write port
	assign rdata_o = entryMem[idx_i];

	assign entries_o = entryMem;

endmodule

`default_nettype wire

//--- tlb/tlbLookup.sv
`default_nettype none

module tlbLookup
	import tlbPkg::*;
(
	input  tlbEntryT  entries_i [TLB_ENTRIES],
	input  asidT      asid_i,
	tlbXlateIf.lookup xlate
);

	vpn2T              reqVpn2;
	logic              oddPage;
	logic              hitMiss;
	tlbIdxT            hitIdx;
	tlbEntryT          hitEntry;
	logic [PAGE_W-1:0] page;
	pfnT               pagePfn;
	cattrT             pageCattr;

	// VPN2 covers one even/odd page pair
	assign reqVpn2 = xlate.vaddr[VADDR_W-1 -: VPN2_W];
	assign oddPage = xlate.vaddr[ODD_PAGE_BIT];

	tlbMatchEncoder u_match (
		.entries_i (entries_i),
		.vpn2_i    (reqVpn2),
		.asid_i    (asid_i),
		.miss_o    (hitMiss),
		.idx_o     (hitIdx)
	);

	// on a miss hitIdx is 0, so entry 0 drives the fields
	assign hitEntry = entries_i[hitIdx];

	assign page = oddPage ? hitEntry[PAGE1_LSB +: PAGE_W] : hitEntry[PAGE_W-1:0];

	assign pagePfn = page[PAGE_PFN_LSB +: PFN_W];
	assign pageCattr = page[PAGE_C_LSB +: CATTR_W];

	// offset passes straight through on 4 KiB pages
	assign xlate.paddr = {pagePfn, xlate.vaddr[PAGE_OFS_W-1:0]};

	assign xlate.miss = hitMiss;
	assign xlate.dirty = page[PAGE_D_BIT];
	assign xlate.valid = page[PAGE_V_BIT];

	// full 3-bit compare against the uncached code
	assign xlate.bypass = (pageCattr == CACHE_UNCACHED);

endmodule

`default_nettype wire

//--- tlb/tlbMatchEncoder.sv
`default_nettype none

module tlbMatchEncoder
	import tlbPkg::*;
(
	input  tlbEntryT entries_i [TLB_ENTRIES],
	input  vpn2T     vpn2_i,
	input  asidT     asid_i,
	output logic     miss_o,
	output tlbIdxT   idx_o
);

	logic [TLB_ENTRIES-1:0] hitVec;

	// one comparator per entry
	for (genvar i = 0; i < TLB_ENTRIES; i++)
	begin : gMatch
		vpn2T entryVpn2;
		asidT entryAsid;
		logic entryGlobal;

		assign entryVpn2 = entries_i[i][ENTRY_VPN2_LSB +: VPN2_W];
		assign entryAsid = entries_i[i][ENTRY_ASID_LSB +: ASID_W];
		assign entryGlobal = entries_i[i][ENTRY_G_BIT];

		// global pages ignore the asid
		assign hitVec[i] = (entryVpn2 == vpn2_i) && (entryGlobal || (entryAsid == asid_i));
	end

	// lowest index wins, scan from the top so it overwrites last
	always_comb
	begin
		idx_o = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (hitVec[i])
			begin
				idx_o = tlbIdxT'(i);
			end
		end
	end

	assign miss_o = ~|hitVec;

endmodule

`default_nettype wire

//--- tlbUnit.f
common/tlbPkg.sv
common/tlbXlateIf.sv
tlb/tlbEntryArray.sv
tlb/tlbMatchEncoder.sv
tlb/tlbLookup.sv
design/tlbTop.sv
dv/tlbTb_asserts.sv
dv/tlbTb.sv
